// File: common/ddr_test_pkg.sv
// ddr3 self-test shared definitions
// data widths, apb register map, reset defaults and fsm states

package ddr_test_pkg;

    // ********************
    // widths
    localparam int word_w     = 16;   // ddr user data word
    localparam int count_w    = 28;   // word count and index
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam int evt_cnt_w  = 16;   // error and pass counters

    typedef logic [word_w-1:0]     word_t;
    typedef logic [count_w-1:0]    count_t;
    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;
    typedef logic [evt_cnt_w-1:0]  evt_cnt_t;

    // ********************
    // register map, byte offsets
    localparam apb_addr_t reg_ctrl       = 8'h00;   // bit 0 start, reads 0
    localparam apb_addr_t reg_word_count = 8'h04;   // rw, 28 bits
    localparam apb_addr_t reg_status     = 8'h08;   // ro
    localparam apb_addr_t reg_err_count  = 8'h0C;   // ro, saturating
    localparam apb_addr_t reg_pass_count = 8'h10;   // ro, saturating

    // status word bit positions
    localparam int st_writing    = 0;
    localparam int st_write_done = 1;
    localparam int st_reading    = 2;
    localparam int st_error      = 3;

    localparam count_t   def_word_count = 28'd256;   // value after reset
    localparam evt_cnt_t evt_cnt_max    = 16'hFFFF;   // counters stop here

    // ********************
    // fsm states
    typedef enum logic [1:0] {wr_idle, wr_run, wr_done} wr_state_t;
    typedef enum logic {rd_idle, rd_run} rd_state_t;

endpackage

// File: design/ddr_test/pattern_writer.sv
// pattern writer
// waits for ddr3 init-done and a start command, then streams a counting
// sequence of word_count words into the ddr write fifo

`timescale 1ns/100ps

module pattern_writer (
    input  logic                 clk_50m,
    input  logic                 rst_n,
    input  logic                 ddr3_init_done,   // async from controller
    input  logic                 start,            // one-cycle pulse
    input  ddr_test_pkg::count_t word_count,
    output logic                 wr_en,
    output ddr_test_pkg::word_t  wr_data,
    output logic                 write_done
);

    logic                      init_d0;
    logic                      init_d1;      // synchronized init-done
    logic                      start_pend;   // start seen, init not yet done
    ddr_test_pkg::count_t      wr_idx;
    ddr_test_pkg::wr_state_t   state;

    // two-flop sync of init-done
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            init_d0 <= 1'b0;
            init_d1 <= 1'b0;
        end else begin
            init_d0 <= ddr3_init_done;
            init_d1 <= init_d0;
        end
    end

    // ********************
    // write fsm
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ddr_test_pkg::wr_idle;
            start_pend <= 1'b0;
            wr_idx     <= '0;
        end else begin
            case (state)
                ddr_test_pkg::wr_idle: begin
                    if ((start || start_pend) && init_d1) begin
                        start_pend <= 1'b0;
                        wr_idx     <= '0;                 // pattern restarts at 0
                        if (word_count != '0)
                            state <= ddr_test_pkg::wr_run;
                    end else if (start) begin
                        start_pend <= 1'b1;               // hold until init done
                    end
                end
                ddr_test_pkg::wr_run: begin
                    if (start) begin
                        state      <= ddr_test_pkg::wr_idle;   // abort, idle first
                        start_pend <= 1'b1;
                    end else if (wr_idx + 1'b1 >= word_count) begin
                        state <= ddr_test_pkg::wr_done;   // last word this cycle
                    end else begin
                        wr_idx <= wr_idx + 1'b1;
                    end
                end
                ddr_test_pkg::wr_done: begin
                    if (start) begin
                        state      <= ddr_test_pkg::wr_idle;
                        start_pend <= 1'b1;
                    end
                end
                default: state <= ddr_test_pkg::wr_idle;
            endcase
        end
    end

    assign wr_en      = (state == ddr_test_pkg::wr_run);
    assign wr_data    = wr_idx[15:0];    // low 16 bits of index
    assign write_done = (state == ddr_test_pkg::wr_done);

    // write_done only follows a write burst and blocks further writes
    a_no_wr_after_done: assert property (@(posedge clk_50m) disable iff (!rst_n)
        $rose(write_done) |-> $past(wr_en) && !wr_en);

endmodule

// File: design/ddr_test/readback_checker.sv
// readback checker
// once the writer is done, reads the ddr back in endless passes and
// compares each returned word against the expected index

`timescale 1ns/100ps

module readback_checker (
    input  logic                 clk_50m,
    input  logic                 rst_n,
    input  logic                 start,        // restart, back to idle
    input  ddr_test_pkg::count_t word_count,
    input  logic                 write_done,
    input  ddr_test_pkg::word_t  rd_data,      // valid one cycle after rd_en
    output logic                 rd_en,
    output logic                 mismatch,     // pulse per bad word
    output logic                 pass_end      // pulse on last compare of a pass
);

    ddr_test_pkg::rd_state_t state;
    ddr_test_pkg::count_t    rd_idx;       // index being requested
    ddr_test_pkg::count_t    rd_idx_d;     // index of word on rd_data
    logic                    rd_vld;       // rd_data holds a requested word

    // ********************
    // read fsm and looping index
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ddr_test_pkg::rd_idle;
            rd_idx <= '0;
        end else if (start) begin
            state  <= ddr_test_pkg::rd_idle;
            rd_idx <= '0;
        end else begin
            case (state)
                ddr_test_pkg::rd_idle: begin
                    if (write_done) begin
                        state  <= ddr_test_pkg::rd_run;   // reads begin next cycle
                        rd_idx <= '0;
                    end
                end
                ddr_test_pkg::rd_run: begin
                    if (rd_idx + 1'b1 >= word_count)
                        rd_idx <= '0;                 // wrap, new pass
                    else
                        rd_idx <= rd_idx + 1'b1;
                end
                default: state <= ddr_test_pkg::rd_idle;
            endcase
        end
    end

    assign rd_en = (state == ddr_test_pkg::rd_run);

    // ********************
    // align expected index with memory latency
    always_ff @(posedge clk_50m) begin
        rd_idx_d <= rd_idx;
    end

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            rd_vld <= 1'b0;
        else if (start)
            rd_vld <= 1'b0;     // drop a response still in flight
        else
            rd_vld <= rd_en;
    end

    // compare
    assign mismatch = rd_vld && (rd_data != rd_idx_d[15:0]);
    assign pass_end = rd_vld && (rd_idx_d + 1'b1 >= word_count);

    // reads only ever follow a finished write
    a_rd_after_write: assert property (@(posedge clk_50m) disable iff (!rst_n)
        rd_en |-> write_done);

endmodule

// File: design/ddr_test/test_status.sv
// test status and apb register file
// holds word count and start command, collects writer and checker
// events into a sticky error flag plus error and pass counters

`timescale 1ns/100ps

module test_status (
    input  logic                    clk_50m,
    input  logic                    rst_n,
    // apb slave
    input  ddr_test_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  ddr_test_pkg::apb_data_t pwdata,
    output ddr_test_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    // test events
    input  logic                    write_done,
    input  logic                    mismatch,
    input  logic                    pass_end,
    input  logic                    wr_en,       // status only
    input  logic                    rd_en,       // status only
    // control out
    output logic                    start,
    output ddr_test_pkg::count_t    word_count,
    output logic                    error_flag
);

    logic                    access;     // apb access phase
    logic                    wr_acc;
    logic                    addr_ok;
    ddr_test_pkg::evt_cnt_t  err_count;
    ddr_test_pkg::evt_cnt_t  pass_count;
    ddr_test_pkg::apb_data_t status_word;

    // ********************
    // apb decode
    assign access = psel && penable;
    assign wr_acc = access && pwrite;

    always_comb begin
        case (paddr)
            ddr_test_pkg::reg_ctrl,
            ddr_test_pkg::reg_word_count,
            ddr_test_pkg::reg_status,
            ddr_test_pkg::reg_err_count,
            ddr_test_pkg::reg_pass_count: addr_ok = 1'b1;
            default:                      addr_ok = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                  // no wait states
    assign pslverr = access && !addr_ok;    // unmapped offset

    // start pulse, one cycle after the ctrl write
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            start <= 1'b0;
        else
            start <= wr_acc && (paddr == ddr_test_pkg::reg_ctrl) && pwdata[0];
    end

    // word count register
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            word_count <= ddr_test_pkg::def_word_count;
        else if (wr_acc && (paddr == ddr_test_pkg::reg_word_count))
            word_count <= pwdata[ddr_test_pkg::count_w-1:0];
    end

    // ********************
    // result tracking, all cleared by start
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            error_flag <= 1'b0;
        else if (start)
            error_flag <= 1'b0;
        else if (mismatch)
            error_flag <= 1'b1;     // sticky
    end

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            err_count <= '0;
        else if (start)
            err_count <= '0;
        else if (mismatch && (err_count != ddr_test_pkg::evt_cnt_max))
            err_count <= err_count + 1'b1;
    end

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n)
            pass_count <= '0;
        else if (start)
            pass_count <= '0;
        else if (pass_end && (pass_count != ddr_test_pkg::evt_cnt_max))
            pass_count <= pass_count + 1'b1;   // saturates
    end

    // status word
    always_comb begin
        status_word                              = '0;
        status_word[ddr_test_pkg::st_writing]    = wr_en;
        status_word[ddr_test_pkg::st_write_done] = write_done;
        status_word[ddr_test_pkg::st_reading]    = rd_en;
        status_word[ddr_test_pkg::st_error]      = error_flag;
    end

    // ********************
    // read mux
    always_comb begin
        case (paddr)
            ddr_test_pkg::reg_word_count: prdata = {4'd0, word_count};
            ddr_test_pkg::reg_status:     prdata = status_word;
            ddr_test_pkg::reg_err_count:  prdata = {16'd0, err_count};
            ddr_test_pkg::reg_pass_count: prdata = {16'd0, pass_count};
            default:                      prdata = '0;   // ctrl reads 0
        endcase
    end

    // apb setup phase always sits between two ctrl writes
    a_start_single: assert property (@(posedge clk_50m) disable iff (!rst_n)
        start |=> !start);

endmodule

// File: design/ddr_test_top.sv
// ddr3 self-test top
// pattern writer, readback checker and apb status block around the
// fifo-style write and read ports of the ddr3 controller

`timescale 1ns/100ps

module ddr_test_top (
    input  logic                    clk_50m,
    input  logic                    rst_n,
    // apb slave
    input  ddr_test_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  ddr_test_pkg::apb_data_t pwdata,
    output ddr_test_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    // ddr user ports
    output logic                    wr_en,
    output ddr_test_pkg::word_t     wr_data,
    output logic                    rd_en,
    input  ddr_test_pkg::word_t     rd_data,
    input  logic                    ddr3_init_done,   // async
    output logic                    error_flag        // led
);

    logic                 start;        // from status block
    ddr_test_pkg::count_t word_count;
    logic                 write_done;   // writer to checker and status
    logic                 mismatch;
    logic                 pass_end;

    // ********************
    // writer
    pattern_writer writer0 (
        .clk_50m        (clk_50m),
        .rst_n          (rst_n),
        .ddr3_init_done (ddr3_init_done),
        .start          (start),
        .word_count     (word_count),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .write_done     (write_done)
    );

    // checker
    readback_checker checker0 (
        .clk_50m    (clk_50m),
        .rst_n      (rst_n),
        .start      (start),
        .word_count (word_count),
        .write_done (write_done),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .mismatch   (mismatch),
        .pass_end   (pass_end)
    );

    // ********************
    // status and apb regs
    test_status status0 (
        .clk_50m    (clk_50m),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .write_done (write_done),
        .mismatch   (mismatch),
        .pass_end   (pass_end),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .start      (start),
        .word_count (word_count),
        .error_flag (error_flag)
    );

endmodule

// File: tests/tb_ddr_mem.sv
// behavioral ddr3 user-port model
// stores each write burst in order and returns one word per rd_en a cycle
// later, wrapping at the burst length, with a single-word fault switch

`timescale 1ns/100ps

module tb_ddr_mem (
    input  logic                 clk_50m,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  ddr_test_pkg::word_t  wr_data,
    input  logic                 rd_en,
    output ddr_test_pkg::word_t  rd_data,
    input  logic                 fault_en,    // flip bit 0 of one word on readback
    input  ddr_test_pkg::count_t fault_idx
);

    ddr_test_pkg::word_t  mem [0:1023];   // covers the test word counts
    ddr_test_pkg::count_t wr_ptr;         // burst length so far
    ddr_test_pkg::count_t wr_slot;
    ddr_test_pkg::count_t rd_ptr;
    logic                 wr_en_d;

    // a write after an idle cycle opens a fresh burst at 0
    assign wr_slot = wr_en_d ? wr_ptr : '0;

    always_ff @(posedge clk_50m) begin
        if (wr_en)
            mem[wr_slot[9:0]] <= wr_data;
    end

    // ********************
    // pointers and read port
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_d <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rd_data <= '0;
        end else begin
            wr_en_d <= wr_en;
            if (wr_en)
                wr_ptr <= wr_slot + 1'b1;
            if (wr_en && !wr_en_d) begin
                rd_ptr <= '0;                 // reads restart with the new burst
            end else if (rd_en) begin
                rd_data <= mem[rd_ptr[9:0]] ^ {15'd0, fault_en && (rd_ptr == fault_idx)};
                rd_ptr  <= (rd_ptr + 1'b1 >= wr_ptr) ? '0 : rd_ptr + 1'b1;   // wrap
            end
        end
    end

endmodule

// File: tests/tb_ddr_test.sv
// ddr3 self-test testbench
// drives the apb port and a ddr user-port model, checks the write pattern,
// readback, fault detection, register map and restart behavior

`timescale 1ns/100ps

module tb_ddr_test;

    logic clk_50m, rst_n, psel, penable, pwrite, pready, pslverr;
    logic wr_en, rd_en, ddr3_init_done, error_flag, fault_en;
    ddr_test_pkg::apb_addr_t paddr;
    ddr_test_pkg::apb_data_t pwdata, prdata, rdata;
    ddr_test_pkg::word_t     wr_data, rd_data;
    ddr_test_pkg::count_t    fault_idx, exp_count;
    ddr_test_pkg::count_t    wr_seen, rd_ptr, rd_exp;   // expected-side indices
    logic                    start_exp, rd_vld, rd_flip, slverr;
    int exp_errs, exp_passes, snap_errs, snap_passes;   // snaps taken in apb access
    int value_errs, proto_errs, n_words;
    string test_name;

    initial begin
        clk_50m = 1'b0;
        forever #10 clk_50m = ~clk_50m;   // 50 MHz
    end

    ddr_test_top dut0 (.clk_50m(clk_50m), .rst_n(rst_n), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data), .ddr3_init_done(ddr3_init_done),
        .error_flag(error_flag));

    tb_ddr_mem mem0 (.clk_50m(clk_50m), .rst_n(rst_n), .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data), .fault_en(fault_en), .fault_idx(fault_idx));

    // ********************
    // expected behavior, from the apb and memory rules
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            {start_exp, rd_vld, rd_flip} <= '0;
            {wr_seen, rd_ptr, rd_exp} <= '0;
            exp_errs   <= 0;
            exp_passes <= 0;
        end else begin
            start_exp <= psel && penable && pwrite && (paddr == ddr_test_pkg::reg_ctrl)
                         && pwdata[0];            // start pulse follows the ctrl write
            if (start_exp) begin
                {wr_seen, rd_ptr} <= '0;
                rd_vld     <= 1'b0;
                exp_errs   <= 0;
                exp_passes <= 0;
            end else begin
                if (wr_en)
                    wr_seen <= wr_seen + 1'b1;
                rd_vld <= rd_en;
                if (rd_en) begin
                    rd_exp  <= rd_ptr;
                    rd_flip <= fault_en && (rd_ptr == fault_idx);
                    rd_ptr  <= (rd_ptr + 1'b1 >= exp_count) ? '0 : rd_ptr + 1'b1;
                end
                if (rd_vld && rd_flip)
                    exp_errs <= exp_errs + 1;     // one bad word per pass
                if (rd_vld && (rd_exp + 1'b1 == exp_count))
                    exp_passes <= exp_passes + 1;
            end
        end
    end

    task automatic value_fail(input string what, input logic [31:0] exp, act);
        value_errs = value_errs + 1;
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    endtask

    task automatic proto_fail(input string what);
        proto_errs = proto_errs + 1;
        $display("%s: %s", test_name, what);
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, act);
        assert (act === exp) else value_fail(what, exp, act);
    endtask

    task automatic abort_run(input string why);
        $display("timeout in %s: %s", test_name, why);
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("TEST FAILED");
        $finish;
    endtask

    // ********************
    // streaming checks
    a_wr_data: assert property (@(posedge clk_50m) disable iff (!rst_n)
        wr_en |-> wr_data == wr_seen[15:0])
        else value_fail("wr_data", $sampled(wr_seen[15:0]), $sampled(wr_data));
    a_wr_init: assert property (@(posedge clk_50m) disable iff (!rst_n)
        wr_en |-> ddr3_init_done) else proto_fail("write issued before init-done");
    a_wr_limit: assert property (@(posedge clk_50m) disable iff (!rst_n)
        wr_en |-> wr_seen < exp_count) else proto_fail("more writes than word count");
    a_wr_run: assert property (@(posedge clk_50m) disable iff (!rst_n)
        wr_en && (wr_seen + 1 < exp_count) |=> wr_en) else proto_fail("write burst broke up");
    a_rd_order: assert property (@(posedge clk_50m) disable iff (!rst_n)
        rd_en |-> wr_seen == exp_count) else proto_fail("read before the last write");
    a_rd_data: assert property (@(posedge clk_50m) disable iff (!rst_n)
        rd_vld |-> rd_data == (rd_exp[15:0] ^ {15'd0, rd_flip}))
        else value_fail("rd_data", $sampled(rd_exp[15:0]) ^ $sampled(rd_flip),
                        $sampled(rd_data));

    // ********************
    // apb master, no wait states expected
    task automatic apb_xfer(input logic write, input ddr_test_pkg::apb_addr_t addr,
                            input ddr_test_pkg::apb_data_t wdata,
                            output ddr_test_pkg::apb_data_t data, output logic err);
        int waits;
        waits = 0;
        @(posedge clk_50m);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        @(posedge clk_50m);
        penable <= 1'b1;        // access phase
        @(negedge clk_50m);
        while (!pready) begin
            waits++;
            if (waits > 16)
                abort_run("apb access never completed, pready stuck low");
            @(negedge clk_50m);
        end
        data        = prdata;
        err         = pslverr;
        snap_errs   = exp_errs;
        snap_passes = exp_passes;
        @(posedge clk_50m);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input ddr_test_pkg::apb_addr_t addr,
                            output ddr_test_pkg::apb_data_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_val("pslverr on read", 0, err);
    endtask

    task automatic apb_write(input ddr_test_pkg::apb_addr_t addr,
                             input ddr_test_pkg::apb_data_t data);
        logic err;
        ddr_test_pkg::apb_data_t unused;
        apb_xfer(1'b1, addr, data, unused, err);
        check_val("pslverr on write", 0, err);
    endtask

    task automatic wait_reads(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk_50m);
        while (!rd_en) begin
            cycles++;
            if (cycles > limit)
                abort_run("readback never started after the writes");
            @(negedge clk_50m);
        end
    endtask

    task automatic wait_error_flag(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk_50m);
        while (!error_flag) begin
            cycles++;
            if (cycles > limit)
                abort_run("error_flag never rose with the fault enabled");
            @(negedge clk_50m);
        end
    endtask

    task automatic wait_passes(input int p);
        int polls;
        polls = 0;
        apb_read(ddr_test_pkg::reg_pass_count, rdata);
        while (rdata < p) begin
            polls++;
            if (polls > p * n_words + 100)
                abort_run("pass counter stalled before the wanted pass count");
            apb_read(ddr_test_pkg::reg_pass_count, rdata);
        end
    endtask

    // flag and counters right after a start
    task automatic check_cleared();
        repeat (2) @(negedge clk_50m);
        check_val("error_flag after start", 0, error_flag);
        apb_read(ddr_test_pkg::reg_err_count, rdata);
        check_val("err_count after start", 0, rdata);
        apb_read(ddr_test_pkg::reg_pass_count, rdata);
        check_val("pass_count after start", 0, rdata);
    endtask

    // ********************
    // stimulus
    initial begin
        void'($urandom(82));
        {rst_n, psel, penable, pwrite, ddr3_init_done, fault_en} = '0;
        paddr      = '0;
        pwdata     = '0;
        fault_idx  = '0;
        exp_count  = ddr_test_pkg::def_word_count;
        value_errs = 0;
        proto_errs = 0;
        test_name  = "reset";
        repeat (8) @(posedge clk_50m);
        rst_n <= 1'b1;
        @(negedge clk_50m);
        check_val("wr_en", 0, wr_en);
        check_val("rd_en", 0, rd_en);
        check_val("error_flag", 0, error_flag);
        check_val("pslverr", 0, pslverr);
        apb_read(ddr_test_pkg::reg_status, rdata);
        check_val("status", 0, rdata);
        apb_read(ddr_test_pkg::reg_word_count, rdata);
        check_val("word_count", 256, rdata);

        test_name = "write";                 // start while init-done is low
        n_words   = $urandom_range(300, 16);
        apb_write(ddr_test_pkg::reg_word_count, n_words);
        exp_count <= n_words;
        apb_read(ddr_test_pkg::reg_word_count, rdata);
        check_val("word_count readback", n_words, rdata);
        apb_write(ddr_test_pkg::reg_ctrl, 32'd1);
        repeat (20) @(posedge clk_50m);
        check_val("writes before init-done", 0, wr_seen);
        ddr3_init_done <= 1'b1;
        wait_reads(n_words + 20);
        check_val("write count", n_words, wr_seen);

        test_name = "readback";
        wait_passes(2);
        apb_read(ddr_test_pkg::reg_err_count, rdata);
        check_val("err_count", 0, rdata);
        @(negedge clk_50m);
        check_val("error_flag", 0, error_flag);

        test_name = "fault";
        @(posedge clk_50m);
        fault_idx <= $urandom_range(n_words - 1, 0);
        fault_en  <= 1'b1;
        apb_write(ddr_test_pkg::reg_ctrl, 32'd1);
        check_cleared();
        wait_error_flag(3 * n_words + 50);
        wait_passes(3);
        apb_read(ddr_test_pkg::reg_err_count, rdata);
        check_val("err_count", snap_errs, rdata);
        apb_read(ddr_test_pkg::reg_pass_count, rdata);
        check_val("pass_count", snap_passes, rdata);

        test_name = "apb";                   // reading with the fault still set
        apb_xfer(1'b0, 8'h14, '0, rdata, slverr);
        check_val("pslverr on read of 0x14", 1, slverr);
        apb_xfer(1'b1, 8'h14, 32'hFFFF_FFFF, rdata, slverr);
        check_val("pslverr on write of 0x14", 1, slverr);
        apb_read(ddr_test_pkg::reg_ctrl, rdata);
        check_val("ctrl", 0, rdata);
        apb_write(ddr_test_pkg::reg_status, 32'h0);
        apb_read(ddr_test_pkg::reg_status, rdata);
        check_val("status after write", (1 << ddr_test_pkg::st_write_done) |
                  (1 << ddr_test_pkg::st_reading) | (1 << ddr_test_pkg::st_error), rdata);

        test_name = "restart";
        @(posedge clk_50m);
        fault_en <= 1'b0;
        apb_write(ddr_test_pkg::reg_ctrl, 32'd1);
        check_cleared();
        wait_reads(n_words + 20);
        check_val("write count", n_words, wr_seen);
        wait_passes(1);
        apb_read(ddr_test_pkg::reg_err_count, rdata);
        check_val("err_count", 0, rdata);

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sources.f
common/ddr_test_pkg.sv
design/ddr_test/pattern_writer.sv
design/ddr_test/readback_checker.sv
design/ddr_test/test_status.sv
design/ddr_test_top.sv
tests/tb_ddr_mem.sv
tests/tb_ddr_test.sv
